//--- build.f
verilog/poly_pkg.sv
verilog/token_fifo.sv
verilog/command_decoder.sv
verilog/coef_store.sv
verilog/setup_engine.sv
verilog/eval_engine.sv
verilog/firing_controller.sv
verilog/poly_actor.sv
testbench/tb_poly_actor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --timescale 1ns/100ps \
        --top-module tb_poly_actor -Mdir obj_dir -o sim_tb -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- testbench/tb_poly_actor.sv
// ******************************
// testbench for the polynomial actor with stream drivers, reference model,
// handshake assertions and the closing report.
// ******************************
`timescale 1ns/100ps
module tb_poly_actor;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic cmd_req = 1'b0;
    poly_pkg::cmd_word_t cmd_data = '0;
    logic cmd_ack;
    logic data_req = 1'b0;
    logic [poly_pkg::word_size-1:0] data_in = '0;
    logic data_ack;
    logic out_req;
    poly_pkg::out_token_t out_token;
    logic out_ack = 1'b0;

    poly_pkg::cmd_word_t cmd_list[$];
    logic [poly_pkg::word_size-1:0] data_list[$];
    poly_pkg::out_token_t exp_q[$];     // tokens still owed by the DUT, oldest first.

    // reference slot table.
    logic [poly_pkg::word_size-1:0] ref_coef [poly_pkg::slot_count][poly_pkg::max_coefs];
    int ref_deg [poly_pkg::slot_count];
    bit ref_valid [poly_pkg::slot_count];

    int value_errors = 0;
    int hs_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int cycle_limit = 2000;
    int n_checked = 0;
    int slow_from = 1 << 30;    // first token index that gets long ack delays.
    int ack_wait = 0;
    logic req_d = 1'b0;

    always #4 clk = ~clk;

    poly_actor dut_i
    (
        .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_data(cmd_data), .cmd_ack(cmd_ack),
        .data_req(data_req), .data_in(data_in), .data_ack(data_ack), .out_req(out_req),
        .out_token(out_token), .out_ack(out_ack)
    );

    // ******************************
    // four-phase rules
    // ******************************
    task automatic handshake_fail(input string what);
        hs_errors++;
        $display("handshake rule broken at %0t: %s", $time, what);
    endtask

    cmd_hold: assert property (@(posedge clk) disable iff (!rst) cmd_req && !cmd_ack |=> cmd_req)
        else handshake_fail("command req dropped before ack.");
    cmd_stable: assert property (@(posedge clk) disable iff (!rst)
        cmd_req |=> !cmd_req || $stable(cmd_data))
        else handshake_fail("command word changed while req was high.");
    cmd_quiet: assert property (@(posedge clk) disable iff (!rst) !cmd_req && !cmd_ack |=> !cmd_ack)
        else handshake_fail("command ack raised without req.");
    data_hold: assert property (@(posedge clk) disable iff (!rst)
        data_req && !data_ack |=> data_req)
        else handshake_fail("data req dropped before ack.");
    data_stable: assert property (@(posedge clk) disable iff (!rst)
        data_req |=> !data_req || $stable(data_in))
        else handshake_fail("data word changed while req was high.");
    data_quiet: assert property (@(posedge clk) disable iff (!rst)
        !data_req && !data_ack |=> !data_ack)
        else handshake_fail("data ack raised without req.");
    out_hold: assert property (@(posedge clk) disable iff (!rst) out_req && !out_ack |=> out_req)
        else handshake_fail("output req dropped before ack.");
    out_stable: assert property (@(posedge clk) disable iff (!rst)
        out_req |=> !out_req || $stable(out_token))
        else handshake_fail("output token changed while req was high.");
    out_quiet: assert property (@(posedge clk) disable iff (!rst) !out_req && !out_ack |=> !out_ack)
        else handshake_fail("output ack raised without req.");

    // ******************************
    // reference model and test list
    // ******************************
    function automatic logic [15:0] horner(input int slot, input logic [15:0] x);
        logic [15:0] acc;
        int i;
        acc = '0;
        for (i = ref_deg[slot]; i >= 0; i--)
            acc = acc * x + ref_coef[slot][i];  // wraps modulo 2^16.
        return acc;
    endfunction

    task automatic add_cmd(input int op, input int slot, input int arg);
        cmd_list.push_back(poly_pkg::cmd_word_t'({8'(op), 3'(slot), 5'(arg)}));
    endtask

    task automatic add_setup(input int slot, input int deg);
        logic [15:0] w;
        add_cmd(poly_pkg::op_stp, slot, deg);
        for (int i = 0; i <= deg; i++)
        begin
            w = 16'($urandom);
            ref_coef[slot][i] = w;
            data_list.push_back(w);     // coefficient 0 goes first.
        end
        ref_deg[slot] = deg;
        ref_valid[slot] = 1'b1;
    endtask

    // one x value and the token the DUT owes for it.
    task automatic push_x(input int slot);
        logic [15:0] x;
        poly_pkg::out_token_t t;
        x = 16'($urandom);
        data_list.push_back(x);
        if (ref_valid[slot])
        begin
            t.result = horner(slot, x);
            t.status = poly_pkg::st_ok;
        end
        else
        begin
            t.result = '0;
            t.status = poly_pkg::st_no_poly;
        end
        exp_q.push_back(t);
    endtask

    task automatic add_point(input int slot);
        add_cmd(poly_pkg::op_evp, slot, $urandom_range(31, 0));  // arg is ignored here.
        push_x(slot);
    endtask

    task automatic add_block(input int slot, input int count);
        add_cmd(poly_pkg::op_evb, slot, count);
        for (int i = 0; i < count; i++)
            push_x(slot);
    endtask

    task automatic build_tests();
        poly_pkg::out_token_t bad;
        add_setup(0, 0);
        add_setup(1, 1);
        add_setup(2, $urandom_range(30, 2));
        add_setup(3, 31);
        for (int s = 0; s < 4; s++)
        begin
            add_point(s);
            add_point(s);
        end
        add_block(2, 5);
        add_block(1, 0);    // no token at all.
        add_point(6);       // slots 6 and 7 were never set up.
        add_block(7, 3);
        add_point(0);
        add_cmd(poly_pkg::op_rst, 0, 0);
        for (int s = 0; s < poly_pkg::slot_count; s++)
            ref_valid[s] = 1'b0;
        add_point(3);
        add_setup(3, $urandom_range(31, 0));
        add_point(3);
        add_cmd(8'h5a, 2, 7);
        bad.result = '0;
        bad.status = poly_pkg::st_bad_opcode;
        exp_q.push_back(bad);
        add_point(3);
        slow_from = exp_q.size();
        // mixed traffic under slow output acks.
        for (int k = 0; k < 14; k++)
        begin
            case ($urandom_range(3, 0))
                0: add_setup($urandom_range(5, 0), $urandom_range(8, 0));
                1: add_point($urandom_range(5, 0));
                2: add_block($urandom_range(5, 0), $urandom_range(6, 1));
                default: add_point($urandom_range(7, 0));
            endcase
        end
    endtask

    // ******************************
    // stream drivers
    // ******************************
    task automatic send_commands();
        foreach (cmd_list[i])
        begin
            @(posedge clk);
            cmd_data <= cmd_list[i];
            cmd_req <= 1'b1;
            do @(posedge clk); while (!cmd_ack);
            cmd_req <= 1'b0;
            do @(posedge clk); while (cmd_ack);
        end
    endtask

    task automatic send_data();
        foreach (data_list[i])
        begin
            @(posedge clk);
            data_in <= data_list[i];
            data_req <= 1'b1;
            do @(posedge clk); while (!data_ack);
            data_req <= 1'b0;
            do @(posedge clk); while (data_ack);
        end
    endtask

    task automatic check_token();
        poly_pkg::out_token_t want;
        if (exp_q.size() == 0)
        begin
            other_errors++;
            $display("got an output token %h at %0t when none was due", out_token, $time);
        end
        else
        begin
            want = exp_q.pop_front();
            assert (out_token == want)
            else
            begin
                value_errors++;
                $display("[ERROR] %0t: token %0d expected result %h status %0d, got %h status %0d",
                         $time, n_checked, want.result, want.status, out_token.result,
                         out_token.status);
            end
            n_checked++;
        end
    endtask

    // the output side checks each token as req rises and acks after a random delay.
    always @(posedge clk)
    begin
        req_d <= out_req;
        if (out_req && !req_d)
        begin
            check_token();
            if (n_checked > slow_from)
                ack_wait = $urandom_range(30, 0);
            else
                ack_wait = $urandom_range(2, 0);
        end
        if (out_req && !out_ack)
        begin
            if (ack_wait == 0)
                out_ack <= 1'b1;
            else
                ack_wait = ack_wait - 1;
        end
        else if (!out_req)
            out_ack <= 1'b0;
    end

    task automatic finish_run();
        $display("error counts: value %0d, handshake %0d, other %0d",
                 value_errors, hs_errors, other_errors);
        if (value_errors + hs_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            other_errors++;
            $display("timeout after %0d cycles with %0d tokens still owed, controller in %s",
                     cycles, exp_q.size(), dut_i.ctrl_i.state.name());
            finish_run();
        end
    end

    initial
    begin
        void'($urandom(32'hf7bfc3d4));
        build_tests();
        cycle_limit = 40 * data_list.size() + 2000;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        fork
            send_commands();
            send_data();
        join
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (50) @(posedge clk);     // room for a stray extra token to show up.
        finish_run();
    end

endmodule

//--- verilog/poly_actor.sv
// ******************************
// actor top level, four-phase stream adapters and the core.
// ******************************
`timescale 1ns/100ps
module poly_actor
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_req,
    input  poly_pkg::cmd_word_t             cmd_data,
    output logic                            cmd_ack,
    input  logic                            data_req,
    input  logic [poly_pkg::word_size-1:0]  data_in,
    output logic                            data_ack,
    output logic                            out_req,
    output poly_pkg::out_token_t            out_token,
    input  logic                            out_ack
);
    logic [1:0] in_req;     // bit 0 is the command port, bit 1 the data port.
    logic [1:0] in_ack;
    logic [1:0] in_full;
    logic [1:0] in_wr;
    poly_pkg::cmd_word_t cmd_q;
    poly_pkg::cmd_word_t cmd;
    logic [poly_pkg::fifo_cw-1:0] cmd_count;
    logic [poly_pkg::fifo_cw-1:0] data_count;
    logic [poly_pkg::fifo_cw-1:0] out_count;
    logic [poly_pkg::word_size-1:0] data_q;
    logic cmd_rd_en;
    logic stp_rd_en;
    logic eval_rd_en;
    logic out_full;
    logic out_pop;
    logic out_wr_en;
    poly_pkg::out_token_t out_wr_token;
    logic get_start;
    logic get_done;
    logic stp_start;
    logic stp_done;
    logic eval_start;
    logic eval_block;
    logic eval_done;
    logic item_done;
    poly_pkg::out_token_t item;
    logic clear_all;
    logic coef_wr_en;
    logic [poly_pkg::addr_bits-1:0] coef_wr_addr;
    logic [poly_pkg::word_size-1:0] coef_wr_data;
    logic deg_wr;
    logic coef_rd_en;
    logic [poly_pkg::addr_bits-1:0] coef_rd_addr;
    logic [poly_pkg::word_size-1:0] coef_word;
    logic [poly_pkg::coef_bits-1:0] query_degree;
    logic query_valid;

    // ******************************
    // four-phase adapters
    // ******************************
    assign in_req = {data_req, cmd_req};
    assign in_wr = in_req & ~in_ack & ~in_full;     // capture on the edge that raises ack.
    assign cmd_ack = in_ack[0];
    assign data_ack = in_ack[1];
    assign out_pop = out_count != '0 && !out_req && !out_ack;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            in_ack <= '0;
            out_req <= 1'b0;
        end
        else
        begin
            in_ack <= (in_ack & in_req) | in_wr;    // ack drops a cycle after req.
            if (out_pop)
                out_req <= 1'b1;    // popped token is on out_token from the next cycle.
            else if (out_ack)
                out_req <= 1'b0;
        end
    end

    token_fifo #(.width($bits(poly_pkg::cmd_word_t)), .depth(poly_pkg::fifo_depth)) cmd_fifo_i
    (
        .clk(clk), .rst(rst), .wr_en(in_wr[0]), .wr_data(cmd_data), .rd_en(cmd_rd_en),
        .rd_data(cmd_q), .count(cmd_count), .full(in_full[0])
    );

    token_fifo #(.width(poly_pkg::word_size), .depth(poly_pkg::fifo_depth)) data_fifo_i
    (
        .clk(clk), .rst(rst), .wr_en(in_wr[1]), .wr_data(data_in),
        .rd_en(stp_rd_en | eval_rd_en), .rd_data(data_q), .count(data_count),
        .full(in_full[1])
    );

    token_fifo #(.width($bits(poly_pkg::out_token_t)), .depth(poly_pkg::fifo_depth)) out_fifo_i
    (
        .clk(clk), .rst(rst), .wr_en(out_wr_en), .wr_data(out_wr_token), .rd_en(out_pop),
        .rd_data(out_token), .count(out_count), .full(out_full)
    );

    command_decoder dec_i
    (
        .clk(clk), .rst(rst), .start(get_start), .fifo_data(cmd_q), .rd_en(cmd_rd_en),
        .done(get_done), .cmd(cmd)
    );

    coef_store store_i
    (
        .clk(clk), .rst(rst), .wr_en(coef_wr_en), .wr_addr(coef_wr_addr),
        .wr_data(coef_wr_data), .rd_en(coef_rd_en), .rd_addr(coef_rd_addr),
        .rd_data(coef_word), .deg_wr(deg_wr), .deg_slot(cmd.slot), .deg_value(cmd.arg),
        .clear_all(clear_all), .query_slot(cmd.slot), .query_degree(query_degree),
        .query_valid(query_valid)
    );

    setup_engine setup_i
    (
        .clk(clk), .rst(rst), .start(stp_start), .cmd(cmd), .data_count(data_count),
        .data_rd_en(stp_rd_en), .data_word(data_q), .coef_wr_en(coef_wr_en),
        .coef_wr_addr(coef_wr_addr), .coef_wr_data(coef_wr_data), .deg_wr(deg_wr),
        .done(stp_done)
    );

    eval_engine eval_i
    (
        .clk(clk), .rst(rst), .start(eval_start), .mode_block(eval_block), .cmd(cmd),
        .data_count(data_count), .data_rd_en(eval_rd_en), .data_word(data_q),
        .query_degree(query_degree), .query_valid(query_valid), .coef_rd_en(coef_rd_en),
        .coef_rd_addr(coef_rd_addr), .coef_word(coef_word), .item_done(item_done),
        .item(item), .out_full(out_full), .done(eval_done)
    );

    firing_controller ctrl_i
    (
        .clk(clk), .rst(rst), .cmd_count(cmd_count), .cmd(cmd), .get_done(get_done),
        .stp_done(stp_done), .eval_item_done(item_done), .eval_item(item),
        .eval_done(eval_done), .out_full(out_full), .get_start(get_start),
        .stp_start(stp_start), .eval_start(eval_start), .eval_block(eval_block),
        .clear_all(clear_all), .out_wr_en(out_wr_en), .out_wr_token(out_wr_token)
    );

endmodule

//--- verilog/firing_controller.sv
// ******************************
// mode-level FSM, engine dispatch and result token writes.
// ******************************
`timescale 1ns/100ps
module firing_controller
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [poly_pkg::fifo_cw-1:0]  cmd_count,
    input  poly_pkg::cmd_word_t           cmd,
    input  logic                          get_done,
    input  logic                          stp_done,
    input  logic                          eval_item_done,
    input  poly_pkg::out_token_t          eval_item,
    input  logic                          eval_done,
    input  logic                          out_full,
    output logic                          get_start,
    output logic                          stp_start,
    output logic                          eval_start,
    output logic                          eval_block,
    output logic                          clear_all,
    output logic                          out_wr_en,
    output poly_pkg::out_token_t          out_wr_token
);
    poly_pkg::ctrl_state_t state;
    poly_pkg::out_token_t tok;

    assign get_start = state == poly_pkg::get_cmd_start;
    assign stp_start = state == poly_pkg::stp_start;
    assign eval_start = state == poly_pkg::evp_start || state == poly_pkg::evb_start;
    assign eval_block = state == poly_pkg::evb_start;
    assign clear_all = state == poly_pkg::rst_slots;
    assign out_wr_en = (state == poly_pkg::evb_output || state == poly_pkg::output_st)
                       && !out_full;
    assign out_wr_token = tok;

    // ******************************
    // state sequencing
    // ******************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= poly_pkg::idle;
        else
        begin
            case (state)
                poly_pkg::idle:
                begin
                    if (cmd_count != '0)
                        state <= poly_pkg::get_cmd_start;
                end
                poly_pkg::get_cmd_start: state <= poly_pkg::get_cmd_wait;
                poly_pkg::get_cmd_wait:
                begin
                    if (get_done)
                    begin
                        case (cmd.opcode)
                            poly_pkg::op_stp: state <= poly_pkg::stp_start;
                            poly_pkg::op_evp: state <= poly_pkg::evp_start;
                            poly_pkg::op_evb: state <= poly_pkg::evb_start;
                            poly_pkg::op_rst: state <= poly_pkg::rst_slots;
                            default: state <= poly_pkg::output_st;  // illegal opcode.
                        endcase
                    end
                end
                poly_pkg::stp_start: state <= poly_pkg::stp_wait;
                poly_pkg::stp_wait:
                begin
                    if (stp_done)
                        state <= poly_pkg::idle;    // set-up writes no token.
                end
                poly_pkg::evp_start: state <= poly_pkg::evp_wait;
                poly_pkg::evp_wait:
                begin
                    if (eval_item_done)
                        state <= poly_pkg::output_st;
                end
                poly_pkg::evb_start: state <= poly_pkg::evb_wait;
                poly_pkg::evb_wait:
                begin
                    if (eval_done)
                        state <= poly_pkg::idle;
                    else if (eval_item_done)
                        state <= poly_pkg::evb_output;
                end
                poly_pkg::evb_output:
                begin
                    // the engine's final done lines up with the last write.
                    if (!out_full)
                        state <= eval_done ? poly_pkg::idle : poly_pkg::evb_wait;
                end
                poly_pkg::output_st:
                begin
                    if (!out_full)
                        state <= poly_pkg::idle;
                end
                default: state <= poly_pkg::idle;
            endcase
        end
    end

    // every decode preloads the bad-opcode token; an evaluation overwrites it.
    always_ff @(posedge clk)
    begin
        if (eval_item_done)
            tok <= eval_item;
        else if (state == poly_pkg::get_cmd_wait && get_done)
        begin
            tok.result <= '0;
            tok.status <= poly_pkg::st_bad_opcode;
        end
    end

endmodule

//--- verilog/eval_engine.sv
// ******************************
// evaluate-point and evaluate-block, Horner's rule per x value.
// ******************************
`timescale 1ns/100ps
module eval_engine
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             mode_block,
    input  poly_pkg::cmd_word_t              cmd,
    input  logic [poly_pkg::fifo_cw-1:0]     data_count,
    output logic                             data_rd_en,
    input  logic [poly_pkg::word_size-1:0]   data_word,
    input  logic [poly_pkg::coef_bits-1:0]   query_degree,
    input  logic                             query_valid,
    output logic                             coef_rd_en,
    output logic [poly_pkg::addr_bits-1:0]   coef_rd_addr,
    input  logic [poly_pkg::word_size-1:0]   coef_word,
    output logic                             item_done,
    output poly_pkg::out_token_t             item,
    input  logic                             out_full,
    output logic                             done
);
    typedef enum logic [2:0] {e_idle, e_fetch, e_xin, e_mac, e_item} eval_state_t;

    eval_state_t state;
    logic [poly_pkg::coef_bits-1:0] left;       // x values still to evaluate.
    logic [poly_pkg::coef_bits-1:0] idx;        // index of the coefficient on coef_word.
    logic [poly_pkg::coef_bits-1:0] rd_idx;
    logic [poly_pkg::word_size-1:0] x_reg;
    logic [poly_pkg::word_size-1:0] acc;
    logic [poly_pkg::word_size-1:0] mac;
    logic fetch_ok;

    // no new x while the output FIFO is full, so a pending token is never overrun.
    assign fetch_ok = state == e_fetch && !out_full;
    assign data_rd_en = fetch_ok && left != '0 && data_count != '0;
    assign done = fetch_ok && left == '0;
    assign item_done = state == e_item;

    // highest coefficient first, then down to index 0.
    assign coef_rd_en = (state == e_xin && query_valid) || (state == e_mac && idx != '0);
    assign rd_idx = (state == e_xin) ? query_degree : idx - 1'b1;
    assign coef_rd_addr = coef_rd_en ? {cmd.slot, rd_idx} : '0;
    assign mac = acc * x_reg + coef_word;       // truncated to 16 bits.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= e_idle;
            left <= '0;
            idx <= '0;
        end
        else
        begin
            if (coef_rd_en)
                idx <= rd_idx;
            case (state)
                e_idle:
                begin
                    if (start)
                    begin
                        left <= mode_block ? cmd.arg : 5'd1;
                        state <= e_fetch;
                    end
                end
                e_fetch:
                begin
                    if (done)
                        state <= e_idle;
                    else if (data_rd_en)
                        state <= e_xin;
                end
                e_xin: state <= query_valid ? e_mac : e_item;
                e_mac:
                begin
                    if (idx == '0)
                        state <= e_item;
                end
                e_item:
                begin
                    left <= left - 1'b1;
                    state <= e_fetch;
                end
                default: state <= e_idle;
            endcase
        end
    end

    // an invalid slot leaves the no-poly token in place.
    always_ff @(posedge clk)
    begin
        if (state == e_xin)
        begin
            x_reg <= data_word;
            acc <= '0;
            item.result <= '0;
            item.status <= poly_pkg::st_no_poly;
        end
        else if (state == e_mac)
        begin
            acc <= mac;
            item.result <= mac;
            item.status <= poly_pkg::st_ok;
        end
    end

endmodule

//--- verilog/setup_engine.sv
// ******************************
// set-up mode that moves N+1 data tokens into one coefficient slot.
// ******************************
`timescale 1ns/100ps
module setup_engine
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  poly_pkg::cmd_word_t              cmd,
    input  logic [poly_pkg::fifo_cw-1:0]     data_count,
    output logic                             data_rd_en,
    input  logic [poly_pkg::word_size-1:0]   data_word,
    output logic                             coef_wr_en,
    output logic [poly_pkg::addr_bits-1:0]   coef_wr_addr,
    output logic [poly_pkg::word_size-1:0]   coef_wr_data,
    output logic                             deg_wr,
    output logic                             done
);
    logic busy;
    logic pend;                                 // a popped word arrives this cycle.
    logic [poly_pkg::coef_bits:0] rd_cnt;       // pops issued so far reach N+1 at most.
    logic [poly_pkg::coef_bits-1:0] wr_idx;
    logic last_wr;

    assign data_rd_en = busy && data_count != '0 && rd_cnt <= {1'b0, cmd.arg};
    assign last_wr = pend && wr_idx == cmd.arg;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy <= 1'b0;
            pend <= 1'b0;
            rd_cnt <= '0;
            wr_idx <= '0;
        end
        else if (start)
        begin
            busy <= 1'b1;
            pend <= 1'b0;
            rd_cnt <= '0;
            wr_idx <= '0;
        end
        else
        begin
            pend <= data_rd_en;
            if (data_rd_en)
                rd_cnt <= rd_cnt + 1'b1;
            if (pend)
                wr_idx <= wr_idx + 1'b1;
            if (last_wr)
                busy <= 1'b0;
        end
    end

    // coefficient 0 comes first in the data stream.
    assign coef_wr_en = pend;
    assign coef_wr_addr = {cmd.slot, wr_idx};
    assign coef_wr_data = data_word;
    assign deg_wr = last_wr;
    assign done = last_wr;

endmodule

//--- verilog/coef_store.sv
// ******************************
// coefficient RAM and the per-slot degree and valid table.
// ******************************
`timescale 1ns/100ps
module coef_store
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_en,
    input  logic [poly_pkg::addr_bits-1:0]     wr_addr,
    input  logic [poly_pkg::word_size-1:0]     wr_data,
    input  logic                               rd_en,
    input  logic [poly_pkg::addr_bits-1:0]     rd_addr,
    output logic [poly_pkg::word_size-1:0]     rd_data,
    input  logic                               deg_wr,
    input  logic [poly_pkg::slot_bits-1:0]     deg_slot,
    input  logic [poly_pkg::coef_bits-1:0]     deg_value,
    input  logic                               clear_all,
    input  logic [poly_pkg::slot_bits-1:0]     query_slot,
    output logic [poly_pkg::coef_bits-1:0]     query_degree,
    output logic                               query_valid
);
    logic [poly_pkg::word_size-1:0] ram [2**poly_pkg::addr_bits];
    logic [poly_pkg::coef_bits-1:0] degree [poly_pkg::slot_count];
    logic [poly_pkg::slot_count-1:0] valid;

    // address is slot in the upper bits, coefficient index below.
    always_ff @(posedge clk)
    begin
        if (wr_en)
            ram[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= ram[rd_addr];
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid <= '0;
            degree <= '{default: '0};
        end
        else if (clear_all)
            valid <= '0;    // degrees stay, they are ignored until the next set-up.
        else if (deg_wr)
        begin
            degree[deg_slot] <= deg_value;
            valid[deg_slot] <= 1'b1;
        end
    end

    assign query_degree = degree[query_slot];
    assign query_valid = valid[query_slot];

endmodule

//--- verilog/command_decoder.sv
// ******************************
// command fetch of one word per start.
// ******************************
`timescale 1ns/100ps
module command_decoder
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  poly_pkg::cmd_word_t fifo_data,
    output logic                rd_en,
    output logic                done,
    output poly_pkg::cmd_word_t cmd
);
    logic pend;

    assign rd_en = start;   // the pop is issued in the start cycle.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pend <= 1'b0;
            done <= 1'b0;
            cmd <= '0;
        end
        else
        begin
            pend <= start;
            done <= pend;   // done rises together with the new command.
            if (pend)
                cmd <= fifo_data;
        end
    end

endmodule

//--- verilog/token_fifo.sv
// ******************************
// synchronous FIFO with population count and registered read data.
// ******************************
`timescale 1ns/100ps
module token_fifo
#(
    parameter int width = 16,
    parameter int depth = 16
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  logic [width-1:0]       wr_data,
    input  logic                   rd_en,
    output logic [width-1:0]       rd_data,
    output logic [$clog2(depth):0] count,
    output logic                   full
);
    logic [width-1:0] mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic do_wr;
    logic do_rd;

    assign full = count == ($clog2(depth) + 1)'(depth);
    assign do_wr = wr_en && !full;      // a write into a full buffer is dropped.
    assign do_rd = rd_en && count != '0;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + ($clog2(depth))'(do_wr);   // pointers wrap at depth.
            rd_ptr <= rd_ptr + ($clog2(depth))'(do_rd);
            count <= count + ($clog2(depth) + 1)'(do_wr) - ($clog2(depth) + 1)'(do_rd);
        end
    end

    // read data shows up the cycle after rd_en.
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];
    end

endmodule

//--- verilog/poly_pkg.sv
// ******************************
// shared sizes, opcode and status encodings, command and result token layouts,
// and the controller state encoding.
// ******************************
package poly_pkg;

    localparam int word_size = 16;
    localparam int slot_count = 8;
    localparam int max_coefs = 32;
    localparam int fifo_depth = 16;
    localparam int slot_bits = $clog2(slot_count);
    localparam int coef_bits = $clog2(max_coefs);   // the degree field spans 0 to 31.
    localparam int addr_bits = slot_bits + coef_bits;
    localparam int fifo_cw = $clog2(fifo_depth) + 1;

    typedef enum logic [7:0] {
        op_stp = 8'h00,
        op_evp = 8'h01,
        op_evb = 8'h02,
        op_rst = 8'h03
    } opcode_t;

    typedef struct packed {
        opcode_t              opcode;
        logic [slot_bits-1:0] slot;
        logic [coef_bits-1:0] arg;  // degree for set-up, count for evaluate-block.
    } cmd_word_t;

    typedef enum logic [1:0] {st_ok, st_no_poly, st_bad_opcode} status_t;

    typedef struct packed {
        logic [word_size-1:0] result;
        status_t              status;
    } out_token_t;

    typedef enum logic [3:0] {
        idle, get_cmd_start, get_cmd_wait, stp_start, stp_wait, evp_start, evp_wait,
        evb_start, evb_wait, evb_output, rst_slots, output_st
    } ctrl_state_t;

endpackage
